// File: hdl/hyper_coll_packer.sv
// ****************************
// Packs popped word pairs into 64-bit collision port lines
// ****************************
`timescale 1ns/100ps
`include "hyper_macros.svh"

module hyper_coll_packer (
	input logic CLK,
	input logic RST,
	input mcu_pkg::pop_word_t pop,
	input logic [1:0] dram_sel,
	output mcu_pkg::mcu_write_t mcu_wr
);
	logic pend_valid;
	logic [`HYPER_WORD_W-1:0] pend_data;
	logic [`HYPER_ADDR_W-1:0] pend_addr;
	logic emit;
	logic hold_even;
	logic [`HYPER_ADDR_W-1:0] emit_addr;
	logic [3:0] emit_we;
	logic [2*`HYPER_WORD_W-1:0] emit_data;
	logic [1:0] wr_req;
	logic [`HYPER_ADDR_W-1:0] wr_addr;
	logic [3:0] wr_we;
	logic [2*`HYPER_WORD_W-1:0] wr_data;

	// An even word waits for its odd partner unless it ends the transfer
	assign hold_even = pop.valid && !pop.addr[0] && !pop.last;

	always_comb
	begin
		emit = 1'b0;
		emit_addr = {pop.addr[`HYPER_ADDR_W-1:1], 1'b0};
		emit_we = 4'b0011;
		emit_data = {`HYPER_WORD_W'(0), pop.data};
		if (pop.valid && pop.addr[0])
		begin
			emit = 1'b1;
			emit_we = {2'b11, {2{pend_valid}}};
			emit_data = {pop.data, pend_data};
		end
		else if (pop.valid && pop.last)
			emit = 1'b1;
		else if (!pop.valid && pend_valid)
		begin
			// Transfer stopped early on an even word
			emit = 1'b1;
			emit_addr = pend_addr;
			emit_data = {`HYPER_WORD_W'(0), pend_data};
		end
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			pend_valid <= 1'b0;
			wr_req <= '0;
		end
		else
		begin
			if (hold_even)
				pend_valid <= 1'b1;
			else if (emit)
				pend_valid <= 1'b0;
			wr_req <= emit ? dram_sel : 2'b00;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (hold_even)
		begin
			pend_data <= pop.data;
			pend_addr <= pop.addr;
		end
		if (emit)
		begin
			wr_addr <= emit_addr;
			wr_we <= emit_we;
			wr_data <= emit_data;
		end
	end

	assign mcu_wr.request = wr_req;
	assign mcu_wr.coll_addr = wr_addr;
	assign mcu_wr.we_array = wr_we;
	assign mcu_wr.data = wr_data;

endmodule

// File: hdl/hyper_macros.svh
// ****************************
// Hyper DRAM mover widths and LSAB depth
// ****************************
`ifndef HYPER_MACROS_SVH
`define HYPER_MACROS_SVH

// LSAB word width
`define HYPER_WORD_W 32

// Word address and transfer count
`define HYPER_ADDR_W 12
`define HYPER_COUNT_W 6

// Tag latched with a marked word
`define HYPER_ANCILL_W 25

// Words per LSAB section, power of two
`define HYPER_LSAB_DEPTH 16

`endif

// File: hdl/hyper_mvblck_todram.sv
// ****************************
// Block mover, pops LSAB words toward DRAM and reports the result
// ****************************
`timescale 1ns/100ps
`include "hyper_macros.svh"

module hyper_mvblck_todram (
	input logic CLK,
	input logic RST,
	input mcu_pkg::move_cmd_t cmd,
	input logic issue,
	input lsab_pkg::lsab_status_t [3:0] status,
	output logic lsab_read,
	output logic [1:0] lsab_section,
	output logic [1:0] dram_sel,
	output mcu_pkg::pop_word_t pop,
	output logic working,
	output logic done,
	output mcu_pkg::move_result_t result
);
	mcu_pkg::mover_state_e state;
	lsab_pkg::lsab_status_t sel_status;
	mcu_pkg::move_result_t result_q;

	logic [1:0] sec_q;
	logic [1:0] dram_sel_q;
	logic [`HYPER_COUNT_W-1:0] count_q;
	logic [`HYPER_COUNT_W-1:0] left;
	logic [`HYPER_ADDR_W-1:0] track_addr;
	logic words_left;

	assign sel_status = status[sec_q];
	assign words_left = (left != '0);

	// Pop the head word this cycle
	assign lsab_read = (state == mcu_pkg::MOVE) && words_left && !sel_status.stop;

	assign lsab_section = sec_q;
	assign dram_sel = dram_sel_q;

	assign pop.valid = lsab_read;
	assign pop.addr = track_addr;
	assign pop.data = sel_status.data;
	assign pop.last = (left == `HYPER_COUNT_W'(1));

	// ******************************
	// State machine
	// ******************************
	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			state <= mcu_pkg::IDLE;
			sec_q <= '0;
			dram_sel_q <= '0;
			count_q <= '0;
			left <= '0;
		end
		else
		begin
			case (state)
				mcu_pkg::IDLE:
				begin
					if (issue)
					begin
						state <= mcu_pkg::MOVE;
						sec_q <= cmd.section;
						dram_sel_q <= cmd.dram_sel;
						count_q <= cmd.count;
						left <= cmd.count;
					end
				end
				mcu_pkg::MOVE:
				begin
					// A zero count falls through on the first cycle
					if (lsab_read)
						left <= left - 1'b1;
					else
						state <= mcu_pkg::REPORT;
				end
				default:
					state <= mcu_pkg::IDLE;
			endcase
		end
	end

	// Address tracking and the completion report
	always_ff @(posedge CLK)
	begin
		if (state == mcu_pkg::IDLE && issue)
			track_addr <= cmd.start_addr;
		else if (lsab_read)
			track_addr <= track_addr + 1'b1;

		if (state == mcu_pkg::MOVE && !lsab_read)
		begin
			result_q.count_sent <= count_q - left;
			result_q.abrupt_stop <= words_left;
			result_q.irq <= sel_status.intr;
			result_q.ancill <= sel_status.ancill;
		end
	end

	assign working = (state != mcu_pkg::IDLE);
	assign done = (state == mcu_pkg::REPORT);
	assign result = result_q;

endmodule

// File: hdl/hyper_todram_top.sv
// ****************************
// LSAB to DRAM block move, top level
// ****************************
`timescale 1ns/100ps

module hyper_todram_top (
	input logic CLK,
	input logic RST,
	input lsab_pkg::lsab_push_t lsab_push,
	input mcu_pkg::move_cmd_t cmd,
	input logic issue,
	output logic working,
	output logic done,
	output mcu_pkg::move_result_t result,
	output mcu_pkg::mcu_write_t mcu_wr
);
	lsab_pkg::lsab_status_t [3:0] status;
	mcu_pkg::pop_word_t pop;
	logic lsab_read;
	logic [1:0] lsab_section;
	logic [1:0] dram_sel;

	lsab_cr lsab_cr_inst (
		.CLK(CLK),
		.RST(RST),
		.lsab_push(lsab_push),
		.lsab_read(lsab_read),
		.lsab_section(lsab_section),
		.status(status)
	);

	hyper_mvblck_todram hyper_mvblck_todram_inst (
		.CLK(CLK),
		.RST(RST),
		.cmd(cmd),
		.issue(issue),
		.status(status),
		.lsab_read(lsab_read),
		.lsab_section(lsab_section),
		.dram_sel(dram_sel),
		.pop(pop),
		.working(working),
		.done(done),
		.result(result)
	);

	// Lines go out on the collision port
	hyper_coll_packer hyper_coll_packer_inst (
		.CLK(CLK),
		.RST(RST),
		.pop(pop),
		.dram_sel(dram_sel),
		.mcu_wr(mcu_wr)
	);

endmodule

// File: hdl/lsab_cr.sv
// ****************************
// Four LSAB sections with push routing and read select
// ****************************
`timescale 1ns/100ps
`include "hyper_macros.svh"

module lsab_cr (
	input logic CLK,
	input logic RST,
	input lsab_pkg::lsab_push_t lsab_push,
	input logic lsab_read,
	input logic [1:0] lsab_section,
	output lsab_pkg::lsab_status_t [3:0] status
);
	logic [3:0] push_sel;
	logic [3:0] pop_sel;

	// ******************************
	// Strobe decode
	// ******************************
	always_comb
	begin
		push_sel = '0;
		pop_sel = '0;
		push_sel[lsab_push.section] = lsab_push.push;
		pop_sel[lsab_section] = lsab_read;
	end

	// ******************************
	// Sections
	// ******************************
	for (genvar i = 0; i < 4; i++)
	begin : g_section
		lsab_section #(
			.DEPTH(`HYPER_LSAB_DEPTH)
		) lsab_section_inst (
			.CLK(CLK),
			.RST(RST),
			.push(push_sel[i]),
			.push_data(lsab_push.data),
			.push_mark(lsab_push.mark),
			.push_ancill(lsab_push.ancill),
			.pop(pop_sel[i]),
			.status(status[i])
		);
	end

endmodule

// File: hdl/lsab_pkg.sv
// ****************************
// LSAB push and section status types
// ****************************
`include "hyper_macros.svh"

package lsab_pkg;

	// Writer side, one push per cycle into one section
	typedef struct packed {
		logic push;
		logic [1:0] section;
		logic [`HYPER_WORD_W-1:0] data;
		logic mark;
		logic [`HYPER_ANCILL_W-1:0] ancill;
	} lsab_push_t;

	// Read side view of one section
	typedef struct packed {
		logic stop;
		logic intr;
		logic [`HYPER_ANCILL_W-1:0] ancill;
		logic [`HYPER_WORD_W-1:0] data;
	} lsab_status_t;

endpackage

// File: hdl/lsab_section.sv
// ****************************
// One LSAB section, a fall-through FIFO with mark count and tag
// ****************************
`timescale 1ns/100ps
`include "hyper_macros.svh"

module lsab_section #(
	parameter int DEPTH = `HYPER_LSAB_DEPTH
) (
	input logic CLK,
	input logic RST,
	input logic push,
	input logic [`HYPER_WORD_W-1:0] push_data,
	input logic push_mark,
	input logic [`HYPER_ANCILL_W-1:0] push_ancill,
	input logic pop,
	output lsab_pkg::lsab_status_t status
);
	localparam int PTR_W = $clog2(DEPTH);

	logic [`HYPER_WORD_W-1:0] mem_data [DEPTH];
	logic mem_mark [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic [PTR_W:0] mark_cnt;
	logic [`HYPER_ANCILL_W-1:0] ancill;
	logic do_push;
	logic do_pop;
	logic mark_in;
	logic mark_out;

	// Full pushes and empty pops are ignored
	assign do_push = push && (count != (PTR_W+1)'(DEPTH));
	assign do_pop = pop && (count != '0);
	assign mark_in = do_push && push_mark;
	assign mark_out = do_pop && mem_mark[rd_ptr];

	always_ff @(posedge CLK)
	begin
		if (do_push)
		begin
			mem_data[wr_ptr] <= push_data;
			mem_mark[wr_ptr] <= push_mark;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			mark_cnt <= '0;
			ancill <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
			mark_cnt <= mark_cnt + (PTR_W+1)'(mark_in) - (PTR_W+1)'(mark_out);
			// Last marked push wins
			if (mark_in)
				ancill <= push_ancill;
		end
	end

	assign status.stop = (count == '0);
	assign status.intr = (mark_cnt != '0);
	assign status.ancill = ancill;
	assign status.data = mem_data[rd_ptr];

endmodule

// File: hdl/mcu_pkg.sv
// ****************************
// Mover command, result and DRAM collision port types
// ****************************
`include "hyper_macros.svh"

package mcu_pkg;

	typedef struct packed {
		logic [`HYPER_ADDR_W-1:0] start_addr;
		logic [`HYPER_COUNT_W-1:0] count;
		logic [1:0] section;
		logic [1:0] dram_sel;
	} move_cmd_t;

	typedef struct packed {
		logic [`HYPER_COUNT_W-1:0] count_sent;
		logic irq;
		logic abrupt_stop;
		logic [`HYPER_ANCILL_W-1:0] ancill;
	} move_result_t;

	// Word handed from the mover to the packer
	typedef struct packed {
		logic valid;
		logic [`HYPER_ADDR_W-1:0] addr;
		logic [`HYPER_WORD_W-1:0] data;
		logic last;
	} pop_word_t;

	// One 64-bit line on the collision write port
	typedef struct packed {
		logic [1:0] request;
		logic [`HYPER_ADDR_W-1:0] coll_addr;
		logic [3:0] we_array;
		logic [2*`HYPER_WORD_W-1:0] data;
	} mcu_write_t;

	typedef enum logic [1:0] {IDLE, MOVE, REPORT} mover_state_e;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build and run the LSAB to DRAM mover testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module hyper_todram_tb \
	-f verilog.f -Mdir obj_dir -o hyper_todram_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/hyper_todram_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation run ended with status $status"
	exit $status
fi

exit 0

// File: verification/hyper_todram_asserts.sv
// ****************************
// Concurrent checks on the block mover and the collision packer
// ****************************
`timescale 1ns/100ps

module hyper_todram_asserts (
	input logic CLK,
	input logic RST,
	input mcu_pkg::mover_state_e state,
	input logic lsab_read,
	input logic issue,
	input logic working,
	input logic done,
	input logic [1:0] lsab_section,
	input logic [1:0] dram_sel,
	input mcu_pkg::mcu_write_t mcu_wr
);

	// Pops only happen while moving
	read_in_move: assert property (@(posedge CLK) disable iff (!RST)
		lsab_read |-> state == mcu_pkg::MOVE)
		else $error("lsab_read asserted outside MOVE");

	// Lines are always even aligned
	coll_addr_even: assert property (@(posedge CLK) disable iff (!RST)
		mcu_wr.request != 2'b00 |-> !mcu_wr.coll_addr[0])
		else $error("odd collision address on a write");

	done_one_cycle: assert property (@(posedge CLK) disable iff (!RST)
		done |=> !done)
		else $error("done held for more than one cycle");

	// A second issue must not relatch the command
	issue_ignored: assert property (@(posedge CLK) disable iff (!RST)
		working && issue |=> $stable(lsab_section) && $stable(dram_sel))
		else $error("issue while working changed the latched command");

endmodule

bind hyper_mvblck_todram hyper_todram_asserts mover_asserts_inst (
	.CLK(CLK),
	.RST(RST),
	.state(state),
	.lsab_read(lsab_read),
	.issue(issue),
	.working(working),
	.done(done),
	.lsab_section(lsab_section),
	.dram_sel(dram_sel),
	.mcu_wr('0)
);

bind hyper_coll_packer hyper_todram_asserts packer_asserts_inst (
	.CLK(CLK),
	.RST(RST),
	.state(mcu_pkg::IDLE),
	.lsab_read(1'b0),
	.issue(1'b0),
	.working(1'b0),
	.done(1'b0),
	.lsab_section(2'b00),
	.dram_sel(dram_sel),
	.mcu_wr(mcu_wr)
);

// File: verification/hyper_todram_tb.sv
// ****************************
// Testbench for the LSAB to DRAM block mover with a queue model
// ****************************
`timescale 1ns/100ps
`include "hyper_macros.svh"

module hyper_todram_tb;
	localparam int WAIT_LIMIT = 200;

	logic CLK;
	logic RST;
	lsab_pkg::lsab_push_t lsab_push;
	mcu_pkg::move_cmd_t cmd;
	logic issue;
	logic working;
	logic done;
	mcu_pkg::move_result_t result;
	mcu_pkg::mcu_write_t mcu_wr;

	logic [15:0] lfsr;
	// Mark bit on top of each stored word
	logic [32:0] model_q [4][$];
	int mark_cnt [4];
	logic [`HYPER_ANCILL_W-1:0] tag [4];
	mcu_pkg::mcu_write_t exp_wr [$];

	hyper_todram_top hyper_todram_top_inst (
		.CLK(CLK),
		.RST(RST),
		.lsab_push(lsab_push),
		.cmd(cmd),
		.issue(issue),
		.working(working),
		.done(done),
		.result(result),
		.mcu_wr(mcu_wr)
	);

	initial CLK = 1'b0;
	always #2 CLK = ~CLK;

	// ******************************
	// Helpers
	// ******************************
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			// Taps 16 14 13 11
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] want);
		if (got !== want)
			stop_run($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, want));
	endtask

	task automatic compare_line(input mcu_pkg::mcu_write_t want);
		logic [63:0] mask;
		for (int i = 0; i < 64; i++)
			mask[i] = want.we_array[i / 16];
		check_value("mcu_wr.request", 64'(mcu_wr.request), 64'(want.request));
		check_value("mcu_wr.coll_addr", 64'(mcu_wr.coll_addr), 64'(want.coll_addr));
		check_value("mcu_wr.we_array", 64'(mcu_wr.we_array), 64'(want.we_array));
		check_value("mcu_wr.data", mcu_wr.data & mask, want.data & mask);
	endtask

	// Every write must match the next expected line
	always @(negedge CLK)
	begin
		if (RST && mcu_wr.request != 2'b00)
		begin
			if (exp_wr.size() == 0)
				stop_run("write on the collision port while no line was expected");
			else
				compare_line(exp_wr.pop_front());
		end
	end

	// ******************************
	// Stimulus
	// ******************************
	task automatic fill(input logic [1:0] sec, input int n, input bit rand_marks);
		logic [31:0] data;
		logic [`HYPER_ANCILL_W-1:0] anc;
		logic mark;
		for (int i = 0; i < n; i++)
		begin
			data = lfsr_bits(32);
			anc = `HYPER_ANCILL_W'(lfsr_bits(25));
			mark = rand_marks ? lfsr_bits(1) : 1'b0;
			if (model_q[sec].size() < `HYPER_LSAB_DEPTH)
			begin
				@(posedge CLK);
				lsab_push <= {1'b1, sec, data, mark, anc};
				model_q[sec].push_back({mark, data});
				if (mark)
				begin
					mark_cnt[sec]++;
					tag[sec] = anc;
				end
			end
		end
		@(posedge CLK);
		lsab_push.push <= 1'b0;
	endtask

	task automatic wait_idle();
		int quiet;
		quiet = 0;
		for (int i = 0; i < WAIT_LIMIT && quiet < 8; i++)
		begin
			@(negedge CLK);
			if (done)
				stop_run("done pulsed again without a new issue");
			if (working || exp_wr.size() != 0)
				quiet = 0;
			else
				quiet++;
		end
		if (quiet < 8)
			stop_run("timeout waiting for the mover to go idle with all lines written");
	endtask

	task automatic run_move(input logic [11:0] start, input logic [5:0] count,
		input logic [1:0] sec, input logic [1:0] dsel, input bit reissue);
		int n;
		int seen;
		logic [32:0] w;
		logic [11:0] a;
		logic pend;
		logic [31:0] pd;
		mcu_pkg::mcu_write_t line;
		n = int'(count);
		if (model_q[sec].size() < n)
			n = model_q[sec].size();
		pend = 1'b0;
		pd = '0;
		// Expected lines from pairing even and odd addresses
		for (int i = 0; i < n; i++)
		begin
			w = model_q[sec].pop_front();
			if (w[32])
				mark_cnt[sec]--;
			a = start + 12'(i);
			line.request = dsel;
			line.coll_addr = {a[11:1], 1'b0};
			if (a[0])
			begin
				line.we_array = {2'b11, pend, pend};
				line.data = {w[31:0], pend ? pd : 32'h0};
				exp_wr.push_back(line);
				pend = 1'b0;
			end
			else if (i == n - 1)
			begin
				line.we_array = 4'b0011;
				line.data = {32'h0, w[31:0]};
				exp_wr.push_back(line);
			end
			else
			begin
				pend = 1'b1;
				pd = w[31:0];
			end
		end

		@(posedge CLK);
		cmd <= {start, count, sec, dsel};
		issue <= 1'b1;
		@(posedge CLK);
		if (reissue)
		begin
			cmd <= {~start, count, ~sec, ~dsel};
			@(posedge CLK);
		end
		issue <= 1'b0;

		seen = 0;
		for (int i = 0; i < WAIT_LIMIT && seen == 0; i++)
		begin
			@(negedge CLK);
			// Working stays high from the cycle after issue through done
			check_value("working", 64'(working), 64'(1));
			if (done)
				seen = 1;
		end
		if (seen == 0)
			stop_run("timeout waiting for done");
		check_value("result.count_sent", 64'(result.count_sent), 64'(n));
		check_value("result.abrupt_stop", 64'(result.abrupt_stop), 64'(n < int'(count)));
		check_value("result.irq", 64'(result.irq), 64'(mark_cnt[sec] != 0));
		check_value("result.ancill", 64'(result.ancill), 64'(tag[sec]));
		// Working drops in the cycle after done
		@(negedge CLK);
		check_value("working", 64'(working), 64'(0));
		wait_idle();
	endtask

	// ******************************
	// Test sequence
	// ******************************
	initial
	begin
		logic [1:0] dsel;
		lfsr = 16'd33883;
		RST = 1'b0;
		lsab_push = '0;
		cmd = '0;
		issue = 1'b0;
		for (int i = 0; i < 4; i++)
		begin
			mark_cnt[i] = 0;
			tag[i] = '0;
		end
		repeat (16) @(posedge CLK);
		RST <= 1'b1;

		// Full transfer, section holds more than the count
		fill(2'd0, 12, 1'b0);
		run_move(12'h100, 6'd10, 2'd0, 2'd1, 1'b0);

		// Early stop, then the same section is seen empty
		fill(2'd1, 5, 1'b0);
		run_move(12'h200, 6'd20, 2'd1, 2'd2, 1'b0);
		run_move(12'h210, 6'd4, 2'd1, 2'd2, 1'b0);

		// Odd start and even last address
		fill(2'd2, 8, 1'b0);
		run_move(12'h0a5, 6'd6, 2'd2, 2'd3, 1'b0);

		// Marked words, partial then the rest
		fill(2'd3, 10, 1'b1);
		run_move(12'h300, 6'd4, 2'd3, 2'd1, 1'b0);
		run_move(12'h304, 6'd8, 2'd3, 2'd1, 1'b0);

		// Zero count, and a second issue during a transfer
		run_move(12'h040, 6'd0, 2'd0, 2'd2, 1'b0);
		fill(2'd0, 10, 1'b1);
		run_move(12'h051, 6'd9, 2'd0, 2'd3, 1'b1);

		// Random transfers with pushes in between
		for (int t = 0; t < 60; t++)
		begin
			fill(2'(lfsr_bits(2)), int'(lfsr_bits(3)), 1'b1);
			fill(2'(lfsr_bits(2)), int'(lfsr_bits(3)), 1'b1);
			dsel = 2'(lfsr_bits(2));
			if (dsel == 2'b00)
				dsel = 2'b11;
			run_move(12'(lfsr_bits(12)), 6'(lfsr_bits(5)), 2'(lfsr_bits(2)), dsel,
				lfsr_bits(1) != 0);
		end

		$display("Simulation passed");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+hdl
hdl/lsab_pkg.sv
hdl/mcu_pkg.sv
hdl/lsab_section.sv
hdl/lsab_cr.sv
hdl/hyper_mvblck_todram.sv
hdl/hyper_coll_packer.sv
hdl/hyper_todram_top.sv
verification/hyper_todram_asserts.sv
verification/hyper_todram_tb.sv
